//--- flist.f
+incdir+.
bch_pkg.sv
lfsr_counter.sv
bch_encode.sv
bch_remainder_check.sv
credit_fifo.sv
bch_word_adapter.sv
bch_link_top.sv
bch_link_asserts.sv
tb_bch_link.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_bch_link
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_bch_link.sv
`include "bch_settings.svh"

module tb_bch_link import bch_pkg::*; ();

	localparam int N = `BCH_N;
	localparam int P = `BCH_N - `BCH_K;
	localparam int QD = `BCH_QDEPTH;
	localparam logic [P:0] GEN_POLY = 11'h537;	// x^10+x^8+x^5+x^4+x^2+x+1
	// about 40 frames of traffic over all tests plus slack
	localparam int TIMEOUT_CYCLES = 40 * N + 300;

	logic clk;
	logic reset;
	logic msg_valid;
	msg_t msg;
	logic msg_credit;
	logic cw_valid;
	codeword_t cw;
	logic cw_credit;
	logic rx_valid;
	codeword_t rx_cw;
	logic rx_credit;
	logic res_valid;
	rx_result_t res;
	logic res_credit;

	msg_t tx_pend[$];	// waiting for a msg credit
	codeword_t rx_pend[$];
	codeword_t cw_got[$];
	rx_result_t res_got[$];
	codeword_t ref_words[$];	// reused by the receive tests
	int msg_cred;
	int rx_cred;
	int cw_owed;	// credits owed back to the DUT
	int res_owed;
	bit cw_open;
	bit res_open;
	int msg_pulses;
	int rx_pulses;
	int cycles = 0;
	int checks;
	int errors;
	logic [31:0] seed;

	bch_link_top bch_link_top_inst (
		.clk(clk),
		.reset(reset),
		.msg_valid(msg_valid),
		.msg(msg),
		.msg_credit(msg_credit),
		.cw_valid(cw_valid),
		.cw(cw),
		.cw_credit(cw_credit),
		.rx_valid(rx_valid),
		.rx_cw(rx_cw),
		.rx_credit(rx_credit),
		.res_valid(res_valid),
		.res(res),
		.res_credit(res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, traffic never completed", cycles);
		$display(">>> FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// msg * x^10 plus its remainder modulo the generator
	function automatic codeword_t ref_encode(msg_t m);
		logic [N-1:0] r;
		r = {m, {P{1'b0}}};
		for (int i = N - 1; i >= P; i--) begin
			if (r[i])
				r = r ^ (N'(GEN_POLY) << (i - P));
		end
		return {m, r[P-1:0]};
	endfunction

	// one to three distinct bit errors
	function automatic codeword_t flip_bits(codeword_t w);
		logic [N-1:0] mask;
		int nflip;
		mask = '0;
		nflip = 1 + int'((next_rand() >> 16) % 3);
		while ($countones(mask) < nflip)
			mask[(next_rand() >> 16) % N] = 1'b1;
		return w ^ mask;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// sample the DUT then drive one cycle of credit traffic
	task automatic step();
		@(negedge clk);
		if (msg_credit) begin
			msg_cred++;
			msg_pulses++;
		end
		if (rx_credit) begin
			rx_cred++;
			rx_pulses++;
		end
		if (cw_valid) begin
			cw_got.push_back(cw);
			cw_owed++;
		end
		if (res_valid) begin
			res_got.push_back(res);
			res_owed++;
		end
		msg_valid = 1'b0;
		if (tx_pend.size() > 0 && msg_cred > 0) begin
			msg = tx_pend.pop_front();
			msg_valid = 1'b1;
			msg_cred--;
		end
		rx_valid = 1'b0;
		if (rx_pend.size() > 0 && rx_cred > 0) begin
			rx_cw = rx_pend.pop_front();
			rx_valid = 1'b1;
			rx_cred--;
		end
		cw_credit = cw_open && cw_owed > 0;
		if (cw_credit)
			cw_owed--;
		res_credit = res_open && res_owed > 0;
		if (res_credit)
			res_owed--;
	endtask

	task automatic wait_cw(int n);
		while (cw_got.size() < n)
			step();
	endtask

	task automatic wait_res(int n);
		while (res_got.size() < n)
			step();
	endtask

	// all credits home on both sides
	task automatic settle();
		while (tx_pend.size() > 0 || rx_pend.size() > 0 || cw_owed > 0 || res_owed > 0
				|| msg_cred != QD || rx_cred != QD)
			step();
		repeat (4) step();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_single();
		msg_t m;
		codeword_t exp;
		m = msg_t'(next_rand() >> 16);
		exp = ref_encode(m);
		cw_got.delete();
		tx_pend.push_back('0);
		tx_pend.push_back(m);
		wait_cw(2);
		check_value("cw for zero msg", cw_got[0], '0);
		check_value("cw.msg", cw_got[1].msg, m);
		check_value("cw.parity", cw_got[1].parity, exp.parity);
	endtask

	task automatic send_stream();
		msg_t m;
		int base;
		cw_got.delete();
		ref_words.delete();
		base = msg_pulses;
		for (int i = 0; i < 16; i++) begin
			m = msg_t'(next_rand() >> 16);
			tx_pend.push_back(m);
			ref_words.push_back(ref_encode(m));
		end
		wait_cw(16);
		for (int i = 0; i < 16; i++)
			check_value("cw", cw_got[i], ref_words[i]);
		check_value("msg_credit pulses", msg_pulses - base, 16);
	endtask

	task automatic hold_tx_output();
		codeword_t exp[$];
		msg_t m;
		int n;
		int base;
		n = 2 * QD + 2;
		cw_got.delete();
		cw_open = 1'b0;
		for (int i = 0; i < n; i++) begin
			m = msg_t'(next_rand() >> 16);
			tx_pend.push_back(m);
			exp.push_back(ref_encode(m));
		end
		repeat (9 * N) step();	// long enough for the pipeline to jam
		base = msg_pulses;
		repeat (3 * N) step();
		check_value("cw_valid beats while held", cw_got.size(), QD);
		check_value("msg_credit pulses while jammed", msg_pulses - base, 0);
		cw_open = 1'b1;
		wait_cw(n);
		for (int i = 0; i < n; i++)
			check_value("cw after release", cw_got[i], exp[i]);
	endtask

	task automatic receive_clean();
		rx_result_t exp;
		res_got.delete();
		foreach (ref_words[i])
			rx_pend.push_back(ref_words[i]);
		wait_res(ref_words.size());
		foreach (ref_words[i]) begin
			exp.msg = ref_words[i].msg;
			exp.corrupt = 1'b0;
			check_value("res clean", res_got[i], exp);
		end
	endtask

	task automatic receive_corrupted();
		codeword_t bad[$];
		codeword_t w;
		rx_result_t exp;
		res_got.delete();
		foreach (ref_words[i]) begin
			w = flip_bits(ref_words[i]);
			bad.push_back(w);
			rx_pend.push_back(w);
		end
		wait_res(bad.size());
		foreach (bad[i]) begin
			exp.msg = bad[i].msg;	// top bits as received
			exp.corrupt = 1'b1;	// distance 7 so never a codeword
			check_value("res corrupted", res_got[i], exp);
		end
	endtask

	task automatic hold_rx_output();
		rx_result_t exp;
		int n;
		int base;
		n = 2 * QD + 2;
		res_got.delete();
		res_open = 1'b0;
		for (int i = 0; i < n; i++)
			rx_pend.push_back(ref_words[i]);
		repeat (2 * N) step();
		base = rx_pulses;
		repeat (2 * N) step();
		check_value("res_valid beats while held", res_got.size(), QD);
		check_value("rx_credit pulses while held", rx_pulses - base, 0);
		res_open = 1'b1;
		wait_res(n);
		for (int i = 0; i < n; i++) begin
			exp.msg = ref_words[i].msg;
			exp.corrupt = 1'b0;
			check_value("res after release", res_got[i], exp);
		end
	endtask

	initial begin
		seed = 32'had4b_0fe4;
		checks = 0;
		errors = 0;
		msg_cred = QD;
		rx_cred = QD;
		cw_owed = 0;
		res_owed = 0;
		cw_open = 1'b1;
		res_open = 1'b1;
		msg_pulses = 0;
		rx_pulses = 0;
		reset = 1'b1;
		msg_valid = 1'b0;
		msg = '0;
		cw_credit = 1'b0;
		rx_valid = 1'b0;
		rx_cw = '0;
		res_credit = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		send_single();
		settle();
		send_stream();
		settle();
		hold_tx_output();
		settle();
		receive_clean();
		settle();
		receive_corrupted();
		settle();
		hold_rx_output();
		settle();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- bch_link_asserts.sv
`include "bch_settings.svh"

module bch_link_asserts import bch_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic cw_valid,
	input  logic res_valid,
	input  logic msg_credit,
	input  logic rx_credit,
	input  cred_t cw_cred,	// adapter's downstream credits
	input  cred_t res_cred,
	input  cred_t tx_fill,	// queue occupancy
	input  cred_t rx_fill
);

	localparam cred_t QMAX = cred_t'(`BCH_QDEPTH);

	// an underflow wraps to a large value and trips this too
	credit_range: assert property (@(posedge clk) disable iff (reset)
		cw_cred <= QMAX && res_cred <= QMAX)
		else $error("credit counter outside 0..%0d", QMAX);

	fill_range: assert property (@(posedge clk) disable iff (reset)
		tx_fill <= QMAX && rx_fill <= QMAX)
		else $error("queue occupancy above depth");

	// the receive pop gating has to leave room for the result in flight
	no_spend_at_zero: assert property (@(posedge clk) disable iff (reset)
		!(res_valid && res_cred == '0))
		else $error("result raised with no receive credit left");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !cw_valid && !res_valid && !msg_credit && !rx_credit)
		else $error("valid or credit high in the cycle after reset");

endmodule

bind bch_link_top bch_link_asserts bch_link_asserts_inst (
	.clk(clk),
	.reset(reset),
	.cw_valid(cw_valid),
	.res_valid(res_valid),
	.msg_credit(msg_credit),
	.rx_credit(rx_credit),
	.cw_cred(bch_word_adapter_inst.cred),
	.res_cred(res_cred),
	.tx_fill(tx_fifo_inst.count),
	.rx_fill(rx_fifo_inst.count)
);

//--- bch_link_top.sv
`include "bch_settings.svh"

module bch_link_top import bch_pkg::*; (
	input  logic clk,
	input  logic reset,
	// transmit in
	input  logic msg_valid,
	input  msg_t msg,
	output logic msg_credit,
	// transmit out
	output logic cw_valid,
	output codeword_t cw,
	input  logic cw_credit,
	// receive in
	input  logic rx_valid,
	input  codeword_t rx_cw,
	output logic rx_credit,
	// receive out
	output logic res_valid,
	output rx_result_t res,
	input  logic res_credit
);

	msg_t tx_head;
	logic tx_ne;
	logic tx_pop;
	logic enc_din;
	logic enc_vdin;
	logic enc_dout;
	codeword_t rx_head;
	logic rx_ne;
	logic rx_pop;
	cred_t res_cred;	// receive-out credits

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transmit path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	credit_fifo #(
		.payload_t(msg_t),
		.DEPTH(`BCH_QDEPTH)
	) tx_fifo_inst (
		.clk(clk),
		.reset(reset),
		.push(msg_valid),
		.push_data(msg),
		.pop(tx_pop),
		.pop_data(tx_head),
		.not_empty(tx_ne),
		.credit(msg_credit)
	);

	bch_word_adapter bch_word_adapter_inst (
		.clk(clk),
		.reset(reset),
		.msg_ready(tx_ne),
		.msg_data(tx_head),
		.msg_pop(tx_pop),
		.enc_din(enc_din),
		.enc_vdin(enc_vdin),
		.enc_dout(enc_dout),
		.cw_valid(cw_valid),
		.cw(cw),
		.cw_credit(cw_credit)
	);

	bch_encode #(
		.N(`BCH_N),
		.K(`BCH_K),
		.T(`BCH_T)
	) bch_encode_inst (
		.clk(clk),
		.reset(reset),
		.din(enc_din),
		.vdin(enc_vdin),
		.dout(enc_dout)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	credit_fifo #(
		.payload_t(codeword_t),
		.DEPTH(`BCH_QDEPTH)
	) rx_fifo_inst (
		.clk(clk),
		.reset(reset),
		.push(rx_valid),
		.push_data(rx_cw),
		.pop(rx_pop),
		.pop_data(rx_head),
		.not_empty(rx_ne),
		.credit(rx_credit)
	);

	// a result in flight still owns one credit
	assign rx_pop = rx_ne & (res_cred > cred_t'(res_valid));

	bch_remainder_check bch_remainder_check_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(rx_pop),
		.in_cw(rx_head),
		.out_valid(res_valid),
		.out_res(res)
	);

	always_ff @(posedge clk) begin
		if (reset)
			res_cred <= cred_t'(`BCH_QDEPTH);
		else
			res_cred <= credit_next(res_cred, res_credit, res_valid);	// spent as result leaves
	end

endmodule

//--- bch_word_adapter.sv
`include "bch_settings.svh"

module bch_word_adapter import bch_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic msg_ready,	// queue has a message
	input  msg_t msg_data,
	output logic msg_pop,
	output logic enc_din,
	input  logic enc_vdin,
	input  logic enc_dout,
	output logic cw_valid,
	output codeword_t cw,
	input  logic cw_credit
);

	localparam int N = `BCH_N;
	localparam int K = `BCH_K;

	logic vdin_q;
	logic start;	// first cycle of an encoder frame
	logic busy;	// a message is inside the encoder
	logic done;
	logic hold_full;	// cw waits for a credit
	logic hold_free;
	logic sr_full;	// finished word parked in sr
	logic can_start;
	msg_t msg_sr;
	logic [N-1:0] sr;	// collects enc_dout
	cred_t cred;

	// the last bit of a frame lands on the first cycle of the next
	assign start = enc_vdin & ~vdin_q;
	assign done = start & busy;
	assign hold_free = ~hold_full | cw_valid;
	assign can_start = ~sr_full & ~(done & ~hold_free);	// skip frame if nowhere to go
	assign msg_pop = start & msg_ready & can_start;
	assign enc_din = start ? (msg_pop & msg_data[K-1]) : msg_sr[K-1];
	assign cw_valid = hold_full & (cred != '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame control and credits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			vdin_q <= 1'b0;
			busy <= 1'b0;
			hold_full <= 1'b0;
			sr_full <= 1'b0;
			msg_sr <= '0;
			cred <= cred_t'(`BCH_QDEPTH);
		end else begin
			vdin_q <= enc_vdin;
			msg_sr <= msg_pop ? {msg_data[K-2:0], 1'b0} : {msg_sr[K-2:0], 1'b0};
			if (start)
				busy <= msg_pop;
			if (done && !hold_free)
				sr_full <= 1'b1;
			else if (sr_full && hold_free)
				sr_full <= 1'b0;
			if ((done || sr_full) && hold_free)
				hold_full <= 1'b1;
			else if (cw_valid)
				hold_full <= 1'b0;
			cred <= credit_next(cred, cw_credit, cw_valid);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// codeword assembly
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (busy)
			sr <= {sr[N-2:0], enc_dout};	// only the last N bits matter
		if (done && hold_free)
			cw <= {sr[N-2:0], enc_dout};
		else if (sr_full && hold_free)
			cw <= sr;
	end

endmodule

//--- credit_fifo.sv
`include "bch_settings.svh"

module credit_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = `BCH_QDEPTH
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  payload_t push_data,
	input  logic pop,
	output payload_t pop_data,
	output logic not_empty,
	output logic credit	// one pulse per freed entry
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;	// occupancy
	logic do_pop;

	// wrap for any depth, not only powers of two
	function automatic logic [AW-1:0] ptr_inc(logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_pop = pop & not_empty;
	assign not_empty = (count != '0);
	assign pop_data = mem[rd_ptr];	// head is visible before the pop

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			credit <= do_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- bch_remainder_check.sv
`include "bch_settings.svh"

module bch_remainder_check import bch_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  codeword_t in_cw,
	output logic out_valid,
	output rx_result_t out_res
);

	localparam int N = `BCH_N;
	localparam int P = `BCH_N - `BCH_K;
	localparam gen_t GEN = encoder_poly(n2m(N), `BCH_T);

	logic [N-1:0] rem;	// low P bits hold the remainder at the end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// long division, one step per message bit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		rem = in_cw;
		for (int i = N - 1; i >= P; i--) begin
			// clear bit i by subtracting g(x) * x^(i-P)
			if (rem[i])
				rem[i -: P + 1] = rem[i -: P + 1] ^ GEN;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result stage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_res.msg <= in_cw.msg;	// systematic, message taken as received
			out_res.corrupt <= |rem[P-1:0];	// any nonzero syndrome
		end
	end

endmodule

//--- bch_encode.sv
`include "bch_settings.svh"

module bch_encode import bch_pkg::*; #(
	parameter int N = `BCH_N,	// codeword bits
	parameter int K = `BCH_K,	// message bits
	parameter int T = `BCH_T	// correctable errors
) (
	input  logic clk,
	input  logic reset,
	input  logic din,	// message bits, MSB first
	output logic vdin,	// window for din
	output logic dout	// codeword bits, one cycle behind din
);

	localparam int M = n2m(N);
	localparam int P = N - K;
	localparam gen_t GEN = encoder_poly(M, T);

	// frame phases, counted from the state after reset
	localparam logic [M-1:0] LAST_DATA = M'(lfsr_count(M, K - 1));
	localparam logic [M-1:0] LAST_FRAME = M'(lfsr_count(M, N - 1));

	logic [M-1:0] count;
	logic [P-1:0] lfsr;	// running remainder
	logic fb;

	lfsr_counter #(
		.M(M)
	) lfsr_counter_inst (
		.clk(clk),
		.reset(reset),
		.count(count)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset)
			vdin <= 1'b1;	// first frame opens right after reset
		else if (count == LAST_DATA)
			vdin <= 1'b0;
		else if (count == LAST_FRAME)
			vdin <= 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// division by the generator
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign fb = vdin & (lfsr[P-1] ^ din);	// no feedback while parity drains

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= '0;
			dout <= 1'b0;
		end else begin
			lfsr <= {lfsr[P-2:0], 1'b0} ^ ({P{fb}} & GEN[P-1:0]);
			// data passes straight through, then the remainder
			// shifts out top bit first and leaves the register clear
			dout <= vdin ? din : lfsr[P-1];
		end
	end

endmodule

//--- lfsr_counter.sv
`include "bch_settings.svh"

module lfsr_counter import bch_pkg::*; #(
	parameter int M = `BCH_M	// field degree, period 2^M - 1
) (
	input  logic clk,
	input  logic reset,
	output logic [M-1:0] count
);

	localparam gf_t TAPS = prim_taps(M);

	// galois form
	// each step multiplies the state by alpha, so the
	// state after s steps is lfsr_count(M, s)
	always_ff @(posedge clk) begin
		if (reset)
			count <= M'(1);
		else
			count <= {count[M-2:0], 1'b0} ^ ({M{count[M-1]}} & TAPS[M-1:0]);
	end

endmodule

//--- bch_pkg.sv
`include "bch_settings.svh"

package bch_pkg;

	localparam int MAX_M = 8;	// widest field the helpers handle

	typedef logic [MAX_M-1:0] gf_t;
	typedef logic [`BCH_K-1:0] msg_t;
	typedef logic [`BCH_N-`BCH_K-1:0] parity_t;
	typedef logic [`BCH_N-`BCH_K:0] gen_t;	// generator incl. x^(N-K) term
	typedef logic [$clog2(`BCH_QDEPTH + 1)-1:0] cred_t;

	// message on top, parity below, sent MSB first
	typedef struct packed {
		msg_t msg;
		parity_t parity;
	} codeword_t;

	typedef struct packed {
		msg_t msg;
		logic corrupt;	// remainder was nonzero
	} rx_result_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(2^m) arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// low terms of a primitive polynomial of degree m
	function automatic gf_t prim_taps(int m);
		case (m)
			5: return gf_t'('h05);
			7: return gf_t'('h09);
			8: return gf_t'('h1d);
			default: return gf_t'('h03);	// x^m + x + 1 for 2, 3, 4, 6
		endcase
	endfunction

	// multiply by alpha
	function automatic gf_t gf_xtime(int m, gf_t a);
		gf_t r;
		r = (a << 1) & gf_t'((1 << m) - 1);
		if (a[m-1])
			r = r ^ prim_taps(m);
		return r;
	endfunction

	function automatic gf_t gf_mul(int m, gf_t a, gf_t b);
		gf_t p;
		gf_t x;
		p = '0;
		x = a;
		for (int i = 0; i < m; i++) begin
			if (b[i])
				p = p ^ x;
			x = gf_xtime(m, x);
		end
		return p;
	endfunction

	// smallest m with 2^m - 1 >= n
	function automatic int n2m(int n);
		int m;
		m = 1;
		while (((1 << m) - 1) < n)
			m++;
		return m;
	endfunction

	// counter state after some steps from reset, i.e. alpha^steps
	function automatic gf_t lfsr_count(int m, int steps);
		gf_t s;
		s = gf_t'(1);
		for (int i = 0; i < steps; i++)
			s = gf_xtime(m, s);
		return s;
	endfunction

	// product of the minimal polynomials of alpha^1 .. alpha^2t
	function automatic gen_t encoder_poly(int m, int t);
		gf_t coef [0:(1<<MAX_M)-1];
		bit covered [0:(1<<MAX_M)-1];
		gf_t root;
		gf_t prev;
		gf_t curr;
		gen_t g;
		int n;
		int deg;
		int e;
		n = (1 << m) - 1;
		for (int i = 0; i < (1 << MAX_M); i++) begin
			coef[i] = '0;
			covered[i] = 1'b0;
		end
		coef[0] = gf_t'(1);
		deg = 0;
		for (int s = 1; s <= 2 * t; s++) begin
			e = s % n;
			while (!covered[e]) begin	// walk the cyclotomic coset
				covered[e] = 1'b1;
				root = lfsr_count(m, e);
				prev = '0;
				for (int i = 0; i <= deg; i++) begin
					curr = coef[i];
					coef[i] = gf_mul(m, curr, root) ^ prev;
					prev = curr;
				end
				coef[deg+1] = prev;
				deg++;
				e = (2 * e) % n;
			end
		end
		g = '0;
		for (int i = 0; i <= deg && i < $bits(gen_t); i++)
			g[i] = coef[i][0];	// coefficients end up binary
		return g;
	endfunction

	// credit count update, one return and one spend per cycle at most
	function automatic cred_t credit_next(cred_t cnt, logic ret, logic spend);
		cred_t nxt;
		case ({ret, spend})
			2'b10: nxt = cnt + 1'b1;
			2'b01: nxt = cnt - 1'b1;
			default: nxt = cnt;
		endcase
		return nxt;
	endfunction

endpackage

//--- bch_settings.svh
`ifndef BCH_SETTINGS_SVH
`define BCH_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// code geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// codeword length, 2^M - 1
`define BCH_N 15

// message length
`define BCH_K 5

// design distance 2T+1, only shapes the generator
`define BCH_T 3

// GF(2^M) degree
`define BCH_M 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link buffering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// entries per queue, also the starting credit count
`define BCH_QDEPTH 4

`endif
